//--- flist.f
verilog/capture_pkg.sv
verilog/transfer_if.sv
verilog/sample_fifo_bank.sv
verilog/transfer_sequencer.sv
verilog/burst_write_master.sv
verilog/capture_dma_top.sv
verification/capture_assertions.sv
verification/capture_tb.sv

//--- verification/capture_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module capture_assertions # (
            parameter int                           CH = 4,
            parameter int                           BURST_SIZE = 8,
            parameter int                           WIDTHB = 4
)
(
    input   logic                                   clock,
    input   logic                                   clock_sreset,
    input   logic [CH-1:0]                          fifo_read,
    input   capture_pkg::address_t                  m_address,
    input   capture_pkg::sample_t                   m_writedata,
    input   logic [WIDTHB-1:0]                      m_burstcount,
    input   logic                                   m_write,
    input   logic                                   m_waitrequest
);
    import capture_pkg::*;

    int unsigned                    fail_count = 0;
    word_count_t                    beats;          // words accepted in the current burst.

    always_ff @ (posedge clock) begin
        if (clock_sreset || !m_write) begin
            beats <= '0;
        end
        else if (!m_waitrequest) begin
            beats <= beats + 1'b1;
        end
    end

    a_burst_size : assert property (@(posedge clock) disable iff (clock_sreset)
        m_write |-> (m_burstcount != '0) && (m_burstcount <= BURST_SIZE))
    else begin
        fail_count++;
        $error("burst count %0d is outside 1 to %0d", m_burstcount, BURST_SIZE);
    end

    // a burst never takes more words than it announced.
    a_burst_overrun : assert property (@(posedge clock) disable iff (clock_sreset)
        m_write |-> (beats < word_count_t'(m_burstcount)))
    else begin
        fail_count++;
        $error("burst at %h carries more words than its count", m_address);
    end

    a_burst_length : assert property (@(posedge clock) disable iff (clock_sreset)
        $fell(m_write) |-> (beats == word_count_t'(m_burstcount)))
    else begin
        fail_count++;
        $error("burst at %h ended after %0d of %0d words", m_address, beats, m_burstcount);
    end

    a_burst_fields_hold : assert property (@(posedge clock) disable iff (clock_sreset)
        m_write && $past(m_write) |-> $stable(m_address) && $stable(m_burstcount))
    else begin
        fail_count++;
        $error("address or burst count changed inside a burst");
    end

    a_stall_hold : assert property (@(posedge clock) disable iff (clock_sreset)
        m_write && m_waitrequest |=>
            m_write && $stable(m_address) && $stable(m_writedata) && $stable(m_burstcount))
    else begin
        fail_count++;
        $error("write port outputs moved during waitrequest");
    end

    a_stall_no_read : assert property (@(posedge clock) disable iff (clock_sreset)
        (fifo_read != '0) |-> m_write && !m_waitrequest && $onehot(fifo_read))
    else begin
        fail_count++;
        $error("a FIFO was popped without an accepted word");
    end

    // bursts start on a word boundary, so the region check stays exact.
    a_word_aligned : assert property (@(posedge clock) disable iff (clock_sreset)
        m_write |-> (m_address[0] == 1'b0))
    else begin
        fail_count++;
        $error("burst address %h is not word aligned", m_address);
    end

endmodule

bind burst_write_master capture_assertions # (
    .CH             (CH),
    .BURST_SIZE     (BURST_SIZE),
    .WIDTHB         (WIDTHB)
) u_assertions (
    .clock          (clock),
    .clock_sreset   (clock_sreset),
    .fifo_read      (fifo_read),
    .m_address      (m_address),
    .m_writedata    (m_writedata),
    .m_burstcount   (m_burstcount),
    .m_write        (m_write),
    .m_waitrequest  (m_waitrequest)
);

`default_nettype wire

//--- verification/capture_tb.sv
`timescale 1ns/10ps
`default_nettype none

module capture_tb;
    import capture_pkg::*;

    localparam int          CH = 4;
    localparam int          BURST_SIZE = 8;
    localparam int          WIDTHB = 4;
    localparam int          FIFO_DEPTH = 32;
    localparam int          REGION_WORDS = 40;
    localparam int          REGION_BYTES = 2 * REGION_WORDS;
    localparam address_t    REGION_BASE = 32'h0000_4000;
    localparam int          SAMPLES_PER_CH = 100;
    localparam int          TOTAL_SAMPLES = CH * SAMPLES_PER_CH;
    localparam int          WATCHDOG_CYCLES = TOTAL_SAMPLES * 40;
    localparam int          HOLD_CYCLES = 200;

    logic                   clock;
    logic                   clock_sreset;
    logic [CH-1:0]          sample_valid;
    logic [CH-1:0]          sample_ready;
    sample_t [CH-1:0]       sample_data;
    logic                   capture_enable;
    address_t               region_base;
    word_count_t            region_words;
    logic                   busy;
    address_t               m_address;
    sample_t                m_writedata;
    logic [1:0]             m_byteenable;
    logic [WIDTHB-1:0]      m_burstcount;
    logic                   m_write;
    logic                   m_waitrequest;

    logic [31:0]            lfsr = 32'h548f;
    logic                   hold_window;    // high while capture is off and the DUT has gone quiet.
    int                     sent_count [CH];
    int                     write_index [CH];
    int                     written_total;
    int                     beat_index;
    int                     data_errors;
    int                     other_errors;
    sample_t                memory [address_t];

    capture_dma_top # (
        .CH             (CH),
        .BURST_SIZE     (BURST_SIZE),
        .WIDTHB         (WIDTHB),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) dut (
        .clock          (clock),
        .clock_sreset   (clock_sreset),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_data    (sample_data),
        .capture_enable (capture_enable),
        .region_base    (region_base),
        .region_words   (region_words),
        .busy           (busy),
        .m_address      (m_address),
        .m_writedata    (m_writedata),
        .m_byteenable   (m_byteenable),
        .m_burstcount   (m_burstcount),
        .m_write        (m_write),
        .m_waitrequest  (m_waitrequest)
    );

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    // the channel number rides in the top four bits of each sample.
    function automatic sample_t expected_sample(int ch, int index);
        return {4'(ch), 12'(index)};
    endfunction

    function automatic address_t expected_address(int ch, int index);
        return REGION_BASE + address_t'(ch * REGION_BYTES)
            + address_t'(2 * (index % REGION_WORDS));
    endfunction

    function automatic int region_of(address_t addr);
        if (addr < REGION_BASE || addr >= REGION_BASE + address_t'(CH * REGION_BYTES)) begin
            return -1;      // outside every region.
        end
        return int'((addr - REGION_BASE) / REGION_BYTES);
    endfunction

    function automatic int samples_sent();
        int total;
        total = 0;
        for (int c = 0; c < CH; c++) begin
            total += sent_count[c];
        end
        return total;
    endfunction

    function automatic int error_total();
        return data_errors + other_errors + int'(dut.u_master.u_assertions.fail_count);
    endfunction

    task automatic print_counts();
        $display("errors: data %0d, assertions %0d, other %0d",
                 data_errors, dut.u_master.u_assertions.fail_count, other_errors);
    endtask

    // only the last lap of each region survives in memory.
    task automatic check_final_memory();
        address_t   addr;
        for (int c = 0; c < CH; c++) begin
            for (int k = SAMPLES_PER_CH - REGION_WORDS; k < SAMPLES_PER_CH; k++) begin
                addr = expected_address(c, k);
                if (!memory.exists(addr)) begin
                    other_errors++;
                    $display("no word was ever written at %h", addr);
                end
                else begin
                    assert (memory[addr] == expected_sample(c, k)) else begin
                        data_errors++;
                        $display("mismatch final memory at %h: expected %h, actual %h",
                                 addr, expected_sample(c, k), memory[addr]);
                    end
                end
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @ (posedge clock) begin : stimulus
        int sent_now;
        logic ready_expected;
        if (clock_sreset) begin
            sample_valid <= '0;
            m_waitrequest <= 1'b0;
        end
        else begin
            for (int c = 0; c < CH; c++) begin
                // the FIFO holds every word that was sent and not yet written.
                ready_expected = (sent_count[c] - write_index[c]) < FIFO_DEPTH;
                assert (sample_ready[c] == ready_expected) else begin
                    other_errors++;
                    $display("mismatch sample_ready ch%0d: expected %b, actual %b",
                             c, ready_expected, sample_ready[c]);
                end
                sent_now = sent_count[c] + ((sample_valid[c] && sample_ready[c]) ? 1 : 0);
                sent_count[c] <= sent_now;
                sample_valid[c] <= (sent_now < SAMPLES_PER_CH) && random_bit();
                sample_data[c] <= expected_sample(c, sent_now);
            end
            m_waitrequest <= random_bit() && random_bit();  // a stall in about one cycle of four.
        end
    end

    always @ (posedge clock) begin : memory_model
        address_t   beat_addr;
        address_t   last_addr;
        int         ch;
        int         index;
        if (clock_sreset || !m_write) begin
            beat_index <= 0;
        end
        else if (!m_waitrequest) begin
            beat_addr = m_address + address_t'(2 * beat_index);
            ch = region_of(beat_addr);
            if (beat_index == 0) begin
                last_addr = m_address + address_t'(2 * (int'(m_burstcount) - 1));
                assert (ch >= 0 && region_of(last_addr) == ch) else begin
                    other_errors++;
                    $display("burst at %h with %0d words leaves its region",
                             m_address, m_burstcount);
                end
            end
            assert (m_byteenable == 2'b11) else begin
                other_errors++;
                $display("byte enables were not all set during a write");
            end
            if (ch < 0) begin
                other_errors++;
                $display("write to %h lies outside every region", beat_addr);
            end
            else begin
                index = write_index[ch];
                assert (beat_addr == expected_address(ch, index)) else begin
                    data_errors++;
                    $display("mismatch placement address ch%0d[%0d]: expected %h, actual %h",
                             ch, index, expected_address(ch, index), beat_addr);
                end
                assert (m_writedata == expected_sample(ch, index)) else begin
                    data_errors++;
                    $display("mismatch placement data ch%0d[%0d]: expected %h, actual %h",
                             ch, index, expected_sample(ch, index), m_writedata);
                end
                write_index[ch] <= index + 1;
                memory[beat_addr] = m_writedata;
                written_total <= written_total + 1;
            end
            beat_index <= beat_index + 1;
        end
        if (hold_window && m_write) begin
            other_errors++;
            $display("a burst was running while capture was disabled");
        end
    end

    initial begin : main
        clock_sreset = 1'b1;
        sample_valid = '0;
        sample_data = '0;
        capture_enable = 1'b1;
        region_base = REGION_BASE;
        region_words = word_count_t'(REGION_WORDS);
        m_waitrequest = 1'b0;
        hold_window = 1'b0;
        written_total = 0;
        beat_index = 0;
        data_errors = 0;
        other_errors = 0;
        for (int c = 0; c < CH; c++) begin
            sent_count[c] = 0;
            write_index[c] = 0;
        end

        repeat (16) @ (posedge clock);
        clock_sreset <= 1'b0;
        assert (!m_write && !busy) else begin
            other_errors++;
            $display("m_write or busy was high right after reset");
        end

        while (samples_sent() < TOTAL_SAMPLES / 4) @ (posedge clock);
        capture_enable <= 1'b0;
        @ (posedge clock);
        while (busy) @ (posedge clock);     // a transfer already accepted may finish.
        hold_window <= 1'b1;
        repeat (HOLD_CYCLES) @ (posedge clock);
        hold_window <= 1'b0;
        assert (samples_sent() > written_total) else begin
            other_errors++;
            $display("no samples were waiting in the FIFOs while capture was disabled");
        end
        capture_enable <= 1'b1;

        while (written_total < TOTAL_SAMPLES) @ (posedge clock);
        repeat (4) @ (posedge clock);
        while (busy) @ (posedge clock);
        assert (written_total == samples_sent()) else begin
            data_errors++;
            $display("mismatch word count: expected %0d, actual %0d",
                     samples_sent(), written_total);
        end
        check_final_memory();

        print_counts();
        if (error_total() == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @ (posedge clock);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/burst_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module burst_write_master # (
            parameter int                           CH = 4,
            parameter int                           BURST_SIZE = 8,
            parameter int                           WIDTHB = 4
)
(
    input   logic                                   clock,
    input   logic                                   clock_sreset,

    transfer_if.sink                                req,
    output  logic [CH-1:0]                          fifo_read,
    input   capture_pkg::sample_t [CH-1:0]          fifo_q,

    output  capture_pkg::address_t                  m_address,
    output  capture_pkg::sample_t                   m_writedata,
    output  logic [1:0]                             m_byteenable,
    output  logic [WIDTHB-1:0]                      m_burstcount,
    output  logic                                   m_write,
    input   logic                                   m_waitrequest
);
    import capture_pkg::*;

    localparam int                  CW = (CH > 1) ? $clog2(CH) : 1;
    localparam word_count_t         BURST_WORDS = word_count_t'(BURST_SIZE);

    master_state_t                  state;
    logic [CW-1:0]                  channel;
    word_count_t                    words_left;     // words not yet given to a burst.
    word_count_t                    burst_left;     // words still owed in this burst.
    word_count_t                    first_len;
    word_count_t                    next_len;
    logic                           beat;

    function automatic word_count_t burst_len(word_count_t words);
        return (words > BURST_WORDS) ? BURST_WORDS : words;
    endfunction

    assign first_len = burst_len(req.req_words);
    assign next_len = burst_len(words_left);

    // A word is taken when the slave does not stall it.
    assign beat = m_write && !m_waitrequest;

    assign req.req_ready = (state == MASTER_IDLE);
    assign m_writedata = fifo_q[channel];   // head of the chosen FIFO.
    assign m_byteenable = {2{m_write}};

    always_comb begin
        fifo_read = '0;
        fifo_read[channel] = beat;
    end

    always_ff @ (posedge clock) begin
        if (clock_sreset) begin
            state <= MASTER_IDLE;
            m_write <= 1'b0;
            words_left <= '0;
            burst_left <= '0;
        end
        else begin
            case (state)
                MASTER_IDLE : begin
                    if (req.req_valid) begin
                        channel <= req.req_channel;
                        m_address <= req.req_address;
                        m_burstcount <= WIDTHB'(first_len);
                        burst_left <= first_len;
                        words_left <= req.req_words - first_len;
                        m_write <= 1'b1;
                        state <= MASTER_BURST;
                    end
                end
                MASTER_BURST : begin
                    // everything holds while the slave stalls.
                    if (beat) begin
                        burst_left <= burst_left - 1'b1;
                        if (burst_left == word_count_t'(1)) begin
                            m_write <= 1'b0;
                            state <= (words_left == '0) ? MASTER_IDLE : MASTER_NEXT;
                        end
                    end
                end
                MASTER_NEXT : begin
                    // the next burst starts right after the words just written.
                    m_address <= m_address + (address_t'(m_burstcount) << 1);
                    m_burstcount <= WIDTHB'(next_len);
                    burst_left <= next_len;
                    words_left <= words_left - next_len;
                    m_write <= 1'b1;
                    state <= MASTER_BURST;
                end
                default : begin
                    m_write <= 1'b0;
                    state <= MASTER_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/capture_dma_top.sv
`timescale 1ns/10ps
`default_nettype none

module capture_dma_top # (
            parameter int                           CH = 4,
            parameter int                           BURST_SIZE = 8,
            parameter int                           WIDTHB = 4,
            parameter int                           FIFO_DEPTH = 32
)
(
    input   logic                                   clock,
    input   logic                                   clock_sreset,

    input   logic [CH-1:0]                          sample_valid,
    output  logic [CH-1:0]                          sample_ready,
    input   capture_pkg::sample_t [CH-1:0]          sample_data,

    input   logic                                   capture_enable,
    input   capture_pkg::address_t                  region_base,
    input   capture_pkg::word_count_t               region_words,
    output  logic                                   busy,

    output  capture_pkg::address_t                  m_address,
    output  capture_pkg::sample_t                   m_writedata,
    output  logic [1:0]                             m_byteenable,
    output  logic [WIDTHB-1:0]                      m_burstcount,
    output  logic                                   m_write,
    input   logic                                   m_waitrequest
);
    import capture_pkg::*;

    sample_t [CH-1:0]               fifo_q;
    word_count_t [CH-1:0]           fifo_words;
    logic [CH-1:0]                  fifo_read;

    transfer_if # (.CH(CH)) req_bus ();

    sample_fifo_bank # (
        .CH             (CH),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) u_fifo_bank (
        .clock          (clock),
        .clock_sreset   (clock_sreset),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_data    (sample_data),
        .fifo_read      (fifo_read),
        .fifo_q         (fifo_q),
        .fifo_words     (fifo_words)
    );

    transfer_sequencer # (
        .CH             (CH)
    ) u_sequencer (
        .clock          (clock),
        .clock_sreset   (clock_sreset),
        .capture_enable (capture_enable),
        .region_base    (region_base),
        .region_words   (region_words),
        .fifo_words     (fifo_words),
        .req            (req_bus.source),
        .busy           (busy)
    );

    burst_write_master # (
        .CH             (CH),
        .BURST_SIZE     (BURST_SIZE),
        .WIDTHB         (WIDTHB)
    ) u_master (
        .clock          (clock),
        .clock_sreset   (clock_sreset),
        .req            (req_bus.sink),
        .fifo_read      (fifo_read),
        .fifo_q         (fifo_q),
        .m_address      (m_address),
        .m_writedata    (m_writedata),
        .m_byteenable   (m_byteenable),
        .m_burstcount   (m_burstcount),
        .m_write        (m_write),
        .m_waitrequest  (m_waitrequest)
    );

endmodule

`default_nettype wire

//--- verilog/capture_pkg.sv
`default_nettype none

package capture_pkg;

    typedef logic [15:0] sample_t;      // one sample is one memory word.
    typedef logic [15:0] word_count_t;
    typedef logic [31:0] address_t;     // byte address on the memory port.

    typedef enum logic [1:0] {
        MASTER_IDLE,
        MASTER_BURST,
        MASTER_NEXT
    } master_state_t;

    typedef enum logic {
        SEQ_SCAN,
        SEQ_OFFER
    } sequencer_state_t;

endpackage

`default_nettype wire

//--- verilog/sample_fifo_bank.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo_bank # (
            parameter int                           CH = 4,
            parameter int                           FIFO_DEPTH = 32
)
(
    input   logic                                   clock,
    input   logic                                   clock_sreset,

    input   logic [CH-1:0]                          sample_valid,
    output  logic [CH-1:0]                          sample_ready,
    input   capture_pkg::sample_t [CH-1:0]          sample_data,

    input   logic [CH-1:0]                          fifo_read,
    output  capture_pkg::sample_t [CH-1:0]          fifo_q,
    output  capture_pkg::word_count_t [CH-1:0]      fifo_words
);
    import capture_pkg::*;

    localparam int                  AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [AW-1:0]       LAST_SLOT = AW'(FIFO_DEPTH - 1);
    localparam word_count_t         FULL_LEVEL = word_count_t'(FIFO_DEPTH);

    for (genvar i = 0; i < CH; i++) begin : g_chan
        sample_t                    mem [FIFO_DEPTH];
        logic [AW-1:0]              wr_ptr;
        logic [AW-1:0]              rd_ptr;
        word_count_t                fill;
        logic                       push;
        logic                       pop;

        assign sample_ready[i] = (fill != FULL_LEVEL);
        assign push = sample_valid[i] && sample_ready[i];
        assign pop = fifo_read[i] && (fill != '0);   // a strobe on an empty FIFO is ignored.

        // first-word-fall-through, so the head is visible without a strobe.
        assign fifo_q[i] = mem[rd_ptr];
        assign fifo_words[i] = fill;

        always_ff @ (posedge clock) begin
            if (push) begin
                mem[wr_ptr] <= sample_data[i];
            end
        end

        always_ff @ (posedge clock) begin
            if (clock_sreset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                fill <= '0;
            end
            else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
                end
                // a push and a pop together leave the level where it was.
                case ({push, pop})
                    2'b10   : fill <= fill + 1'b1;
                    2'b01   : fill <= fill - 1'b1;
                    default : fill <= fill;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/transfer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface transfer_if # (
            parameter int           CH = 4
);
    import capture_pkg::*;

    localparam int CW = (CH > 1) ? $clog2(CH) : 1;

    logic                   req_valid;
    logic                   req_ready;
    logic [CW-1:0]          req_channel;
    address_t               req_address;    // first byte of the transfer.
    word_count_t            req_words;

    modport source (
        output  req_valid, req_channel, req_address, req_words,
        input   req_ready
    );

    modport sink (
        input   req_valid, req_channel, req_address, req_words,
        output  req_ready
    );

endinterface

`default_nettype wire

//--- verilog/transfer_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module transfer_sequencer # (
            parameter int                           CH = 4
)
(
    input   logic                                   clock,
    input   logic                                   clock_sreset,

    input   logic                                   capture_enable,
    input   capture_pkg::address_t                  region_base,
    input   capture_pkg::word_count_t               region_words,
    input   capture_pkg::word_count_t [CH-1:0]      fifo_words,

    transfer_if.source                              req,
    output  logic                                   busy
);
    import capture_pkg::*;

    localparam int                  CW = (CH > 1) ? $clog2(CH) : 1;
    localparam logic [CW-1:0]       LAST_CH = CW'(CH - 1);

    sequencer_state_t               state;
    logic [CW-1:0]                  scan_ch;
    logic [CW-1:0]                  next_ch;
    logic [CW-1:0]                  last_ch;
    word_count_t                    offset [CH];    // word offset inside each region.
    word_count_t                    fill;
    word_count_t                    room;
    word_count_t                    advanced;
    address_t                       chan_base;
    logic                           draining;
    logic                           eligible;

    assign fill = fifo_words[scan_ch];
    assign room = region_words - offset[scan_ch];   // words left before the region wraps.
    assign next_ch = (scan_ch == LAST_CH) ? '0 : scan_ch + 1'b1;

    // The master pops only the channel it was last given, so that one fill
    // is not trusted until the master is idle again.
    assign draining = !req.req_ready && (scan_ch == last_ch);
    assign eligible = capture_enable && (fill != '0) && !draining;

    // each region is region_words long, two bytes per word.
    assign chan_base = region_base + ((address_t'(scan_ch) * address_t'(region_words)) << 1);
    assign advanced = offset[req.req_channel] + req.req_words;

    assign req.req_valid = (state == SEQ_OFFER);
    assign busy = (state == SEQ_OFFER) || !req.req_ready;

    always_ff @ (posedge clock) begin
        if (clock_sreset) begin
            state <= SEQ_SCAN;
            scan_ch <= '0;
            last_ch <= '0;
            for (int i = 0; i < CH; i++) begin
                offset[i] <= '0;
            end
        end
        else begin
            case (state)
                SEQ_SCAN : begin
                    if (eligible) begin
                        req.req_channel <= scan_ch;
                        req.req_address <= chan_base + (address_t'(offset[scan_ch]) << 1);
                        req.req_words <= (fill < room) ? fill : room;
                        state <= SEQ_OFFER;
                    end
                    else begin
                        scan_ch <= next_ch;     // nothing to move here, look at the next one.
                    end
                end
                SEQ_OFFER : begin
                    // the request fields stay put until the master takes them.
                    if (req.req_ready) begin
                        offset[req.req_channel] <= (advanced >= region_words) ? '0 : advanced;
                        last_ch <= req.req_channel;
                        scan_ch <= next_ch;
                        state <= SEQ_SCAN;
                    end
                end
                default : begin
                    state <= SEQ_SCAN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
